/* source/bf_params.svh */
// Butterfly parameters
`ifndef BF_PARAMS_SVH
`define BF_PARAMS_SVH

// Width of one share word
`define BF_WIDTH 24

// Dilithium modulus, just under 2^23
`define BF_Q 8380417

// Barrett reduction of a 48-bit product
// M is floor(2^K / q)
`define BF_BARRETT_K 48
`define BF_BARRETT_M 33587228

// Pipeline depths of the two arithmetic units
`define BF_ADD_SUB_LATENCY 2
`define BF_MULT_LATENCY 3

`endif

/* source/mask_pkg.sv */
// Masked share types
`default_nettype none

`include "bf_params.svh"

package mask_pkg;

    // One arithmetic share, always kept below q
    typedef logic [`BF_WIDTH-1:0] share_t;

    // Two shares whose sum mod q is the real value
    typedef share_t [1:0] share_pair_t;

    // Fresh randomness per cycle
    // Word 0 for add, word 1 for sub, word 2 for mult
    typedef share_t [2:0] rnd_bundle_t;

    // Unreduced share sum, holds values up to 3q
    typedef logic [`BF_WIDTH+1:0] share_wide_t;

    // Bring a value below 3q into the range 0 to q-1
    function automatic share_t reduce_3q(input share_wide_t x);
        share_wide_t q1;
        share_wide_t q2;
        q1 = share_wide_t'(`BF_Q);
        q2 = share_wide_t'(2 * `BF_Q);
        if (x >= q2) begin
            return share_t'(x - q2);
        end else if (x >= q1) begin
            return share_t'(x - q1);
        end
        return share_t'(x);
    endfunction

endpackage

`default_nettype wire

/* source/bf_mode_pkg.sv */
// Butterfly mode
`default_nettype none

package bf_mode_pkg;

    // gs computes the inverse NTT butterfly
    // pwm computes a plain pointwise product
    typedef enum logic {
        bf_gs  = 1'b0,
        bf_pwm = 1'b1
    } bf_mode_t;

endpackage

`default_nettype wire

/* source/masked_mod_add_sub.sv */
// Masked modular adder and subtractor
`default_nettype none

`include "bf_params.svh"

module masked_mod_add_sub (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  sub_i,
    input  mask_pkg::share_pair_t u_i,
    input  mask_pkg::share_pair_t v_i,
    input  mask_pkg::share_t      rnd_i,
    output mask_pkg::share_pair_t res_o
);

    import mask_pkg::*;

    localparam share_wide_t q_wide  = share_wide_t'(`BF_Q);
    localparam share_t      q_share = share_t'(`BF_Q);

    share_wide_t [1:0] v_term;
    share_wide_t [1:0] sum_d;
    share_wide_t [1:0] sum_q;

    // Stage 1 operand terms
    // Subtraction uses q - v so every term stays positive
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (sub_i) begin
                v_term[i] = q_wide - share_wide_t'(v_i[i]);
            end else begin
                v_term[i] = share_wide_t'(v_i[i]);
            end
        end
        // Remask with +rnd on share 0 and -rnd on share 1
        sum_d[0] = share_wide_t'(u_i[0]) + v_term[0] + share_wide_t'(rnd_i);
        sum_d[1] = share_wide_t'(u_i[1]) + v_term[1] + (q_wide - share_wide_t'(rnd_i));
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            sum_q <= '0;
        end else if (zeroize_i) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum_d;
        end
    end

    // Stage 2 reduction, both shares below 3q on entry
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o[0] <= reduce_3q(sum_q[0]);
            res_o[1] <= reduce_3q(sum_q[1]);
        end
    end

    res_range_a: assert property (@(posedge clk) disable iff (!reset_n)
        (res_o[0] < q_share) && (res_o[1] < q_share));

endmodule

`default_nettype wire

/* source/masked_mod_mult.sv */
// Masked modular multiplier
`default_nettype none

`include "bf_params.svh"

module masked_mod_mult (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  mask_pkg::share_pair_t a_i,
    input  mask_pkg::share_pair_t b_i,
    input  mask_pkg::share_t      rnd_i,
    output mask_pkg::share_pair_t res_o
);

    import mask_pkg::*;

    localparam int prod_width = 2 * `BF_WIDTH;
    // Product times Barrett constant needs 48 + 26 bits
    localparam int ext_width  = prod_width + `BF_WIDTH + 2;

    localparam logic [prod_width-1:0] q_prod    = prod_width'(`BF_Q);
    localparam logic [ext_width-1:0]  barrett_m = ext_width'(`BF_BARRETT_M);
    localparam share_wide_t           q_wide    = share_wide_t'(`BF_Q);
    localparam share_t                q_share   = share_t'(`BF_Q);

    // Cross products, in order a0b0, a0b1, a1b0, a1b1
    logic [3:0][prod_width-1:0] prod_q;
    share_t [3:0]               red_q;
    share_wide_t [1:0]          mix_d;

    // Barrett estimate is at most one q short
    function automatic share_t barrett_reduce(input logic [prod_width-1:0] x);
        logic [ext_width-1:0]  x_m;
        logic [prod_width-1:0] q_est;
        logic [prod_width-1:0] r;
        x_m   = ext_width'(x) * barrett_m;
        q_est = prod_width'(x_m >> `BF_BARRETT_K);
        r     = x - q_est * q_prod;
        if (r >= q_prod) begin
            r = r - q_prod;
        end
        return share_t'(r);
    endfunction

    // Stage 1 share-wise products
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
        end else begin
            prod_q[0] <= prod_width'(a_i[0]) * prod_width'(b_i[0]);
            prod_q[1] <= prod_width'(a_i[0]) * prod_width'(b_i[1]);
            prod_q[2] <= prod_width'(a_i[1]) * prod_width'(b_i[0]);
            prod_q[3] <= prod_width'(a_i[1]) * prod_width'(b_i[1]);
        end
    end

    // Stage 2 reduction of each product
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            red_q <= '0;
        end else if (zeroize_i) begin
            red_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                red_q[i] <= barrett_reduce(prod_q[i]);
            end
        end
    end

    // Share 0 gets a0*b, share 1 gets a1*b, split again by rnd
    always_comb begin
        mix_d[0] = share_wide_t'(red_q[0]) + share_wide_t'(red_q[1])
                 + share_wide_t'(rnd_i);
        mix_d[1] = share_wide_t'(red_q[2]) + share_wide_t'(red_q[3])
                 + (q_wide - share_wide_t'(rnd_i));
    end

    // Stage 3 output shares
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else begin
            res_o[0] <= reduce_3q(mix_d[0]);
            res_o[1] <= reduce_3q(mix_d[1]);
        end
    end

    // Barrett bound holds only for reduced operands
    operand_range_a: assert property (@(posedge clk) disable iff (!reset_n)
        (a_i[0] < q_share) && (a_i[1] < q_share) &&
        (b_i[0] < q_share) && (b_i[1] < q_share));

endmodule

`default_nettype wire

/* source/masked_gs_butterfly.sv */
// Masked Gentleman-Sande butterfly
`default_nettype none

`include "bf_params.svh"

module masked_gs_butterfly (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  bf_mode_pkg::bf_mode_t mode_i,
    input  mask_pkg::share_pair_t opu_i,
    input  mask_pkg::share_pair_t opv_i,
    input  mask_pkg::share_pair_t opw_i,
    input  mask_pkg::rnd_bundle_t rnd_i,
    output mask_pkg::share_pair_t u_o,
    output mask_pkg::share_pair_t v_o
);

    import mask_pkg::*;
    import bf_mode_pkg::*;

    localparam int as_lat     = `BF_ADD_SUB_LATENCY;
    localparam int mult_lat   = `BF_MULT_LATENCY;
    localparam int gs_lat     = as_lat + mult_lat + 1;
    localparam int hold_width = $clog2(gs_lat + 1);

    localparam logic [hold_width-1:0] hold_max = hold_width'(gs_lat);
    localparam logic [hold_width-1:0] hold_min = hold_width'(gs_lat - 1);

    share_pair_t add_res;
    share_pair_t sub_res;
    share_pair_t mult_res;
    share_pair_t mult_a;
    share_pair_t mult_b;
    bf_mode_t    mult_mode_d;
    logic        pwm_in;

    // w and mode wait for the subtractor
    share_pair_t w_q [as_lat];
    bf_mode_t    mode_q [as_lat];
    // Sum and mode wait for the multiplier
    share_pair_t sum_q [mult_lat];
    bf_mode_t    mult_mode_q [mult_lat];

    logic [hold_width-1:0] mode_hold_cnt;

    masked_mod_add_sub add_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b0),
        .u_i       (opu_i),
        .v_i       (opv_i),
        .rnd_i     (rnd_i[0]),
        .res_o     (add_res)
    );

    masked_mod_add_sub sub_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b1),
        .u_i       (opu_i),
        .v_i       (opv_i),
        .rnd_i     (rnd_i[1]),
        .res_o     (sub_res)
    );

    // pwm items skip the add/sub stage and enter the multiplier at once
    assign pwm_in      = (mode_i == bf_pwm);
    assign mult_a      = pwm_in ? opu_i : sub_res;
    assign mult_b      = pwm_in ? opv_i : w_q[as_lat-1];
    assign mult_mode_d = pwm_in ? bf_pwm : mode_q[as_lat-1];

    masked_mod_mult mult_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .rnd_i     (rnd_i[2]),
        .res_o     (mult_res)
    );

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            for (int i = 0; i < as_lat; i++) begin
                w_q[i]    <= '0;
                mode_q[i] <= bf_gs;
            end
            for (int i = 0; i < mult_lat; i++) begin
                sum_q[i]       <= '0;
                mult_mode_q[i] <= bf_gs;
            end
        end else begin
            w_q[0]         <= opw_i;
            mode_q[0]      <= mode_i;
            sum_q[0]       <= add_res;
            mult_mode_q[0] <= mult_mode_d;
            for (int i = 1; i < as_lat; i++) begin
                w_q[i]    <= w_q[i-1];
                mode_q[i] <= mode_q[i-1];
            end
            for (int i = 1; i < mult_lat; i++) begin
                sum_q[i]       <= sum_q[i-1];
                mult_mode_q[i] <= mult_mode_q[i-1];
            end
        end
    end

    // Output register, steered by the mode of the item in the last stage
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            u_o <= '0;
            v_o <= '0;
        end else if (zeroize_i) begin
            u_o <= '0;
            v_o <= '0;
        end else if (mult_mode_q[mult_lat-1] == bf_pwm) begin
            u_o <= mult_res;
            v_o <= '0;
        end else begin
            u_o <= sum_q[mult_lat-1];
            v_o <= mult_res;
        end
    end

    // Cycles since the last mode change, saturating at the gs latency
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mode_hold_cnt <= hold_max;
        end else if (zeroize_i) begin
            mode_hold_cnt <= hold_max;
        end else if (mode_i != mode_q[0]) begin
            mode_hold_cnt <= '0;
        end else if (mode_hold_cnt != hold_max) begin
            mode_hold_cnt <= mode_hold_cnt + hold_width'(1);
        end
    end

    // Leaving gs early would drop items still in the subtractor
    mode_hold_a: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        ((mode_i != mode_q[0]) && (mode_q[0] == bf_gs)) |-> (mode_hold_cnt >= hold_min));

endmodule

`default_nettype wire

/* tb/tb_masked_gs_butterfly.sv */
// Masked butterfly testbench
`default_nettype none

`include "bf_params.svh"

module tb_masked_gs_butterfly;

    timeunit 1ns;
    timeprecision 1ps;

    import mask_pkg::*;
    import bf_mode_pkg::*;

    localparam int unsigned q_mod = `BF_Q;
    localparam int max_items = 64;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        zeroize_i;
    bf_mode_t    mode_i;
    share_pair_t opu_i;
    share_pair_t opv_i;
    share_pair_t opw_i;
    rnd_bundle_t rnd_i;
    share_pair_t u_o;
    share_pair_t v_o;

    // Trace records
    int unsigned tr_id [max_items];
    int unsigned tr_mode [max_items];
    int unsigned tr_u [max_items];
    int unsigned tr_v [max_items];
    int unsigned tr_w [max_items];
    int unsigned tr_eu [max_items];
    int unsigned tr_ev [max_items];
    int          trace_n = 0;

    // Pending results in order of their due cycle
    int          due_q [$];
    int unsigned eu_q [$];
    int unsigned ev_q [$];
    int unsigned tid_q [$];
    share_t      refresh_s0 [$];

    int       cyc = 0;
    int       errors = 0;
    int       checks = 0;
    int       test_checks [8];
    int       test_errs [8];
    bf_mode_t cur_mode = bf_gs;

    masked_gs_butterfly masked_gs_butterfly_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .opu_i     (opu_i),
        .opv_i     (opv_i),
        .opw_i     (opw_i),
        .rnd_i     (rnd_i),
        .u_o       (u_o),
        .v_o       (v_o)
    );

    always #5 clk = ~clk;

    function automatic share_t rand_share();
        return share_t'($urandom % q_mod);
    endfunction

    // Split a value into two fresh shares
    function automatic share_pair_t mask_value(input int unsigned val);
        share_pair_t p;
        int unsigned r;
        r = $urandom % q_mod;
        p[0] = share_t'(r);
        p[1] = share_t'((val + q_mod - r) % q_mod);
        return p;
    endfunction

    function automatic int unsigned recombine(input share_pair_t p);
        int unsigned s;
        s = 32'(p[0]) + 32'(p[1]);
        if (s >= q_mod) begin
            s = s - q_mod;
        end
        return s;
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        cyc = cyc + 1;
    endtask

    task automatic drive_rnd();
        rnd_bundle_t r;
        for (int i = 0; i < 3; i++) begin
            r[i] = rand_share();
        end
        rnd_i <= r;
    endtask

    task automatic drive_idle();
        step_cycle();
        zeroize_i <= 1'b0;
        mode_i    <= cur_mode;
        opu_i     <= '0;
        opv_i     <= '0;
        opw_i     <= '0;
        drive_rnd();
    endtask

    task automatic drive_item(input int k);
        step_cycle();
        zeroize_i <= 1'b0;
        mode_i    <= cur_mode;
        opu_i     <= mask_value(tr_u[k]);
        opv_i     <= mask_value(tr_v[k]);
        opw_i     <= mask_value(tr_w[k]);
        drive_rnd();
        // gs needs add/sub, multiplier and output register
        due_q.push_back(cur_mode == bf_pwm ? cyc + 4 : cyc + 6);
        eu_q.push_back(tr_eu[k]);
        ev_q.push_back(tr_ev[k]);
        tid_q.push_back(tr_id[k]);
    endtask

    task automatic apply_zeroize();
        step_cycle();
        zeroize_i <= 1'b1;
        opu_i     <= '0;
        opv_i     <= '0;
        opw_i     <= '0;
        // Anything not yet visible is lost
        while (due_q.size() > 0 && due_q[due_q.size()-1] > cyc) begin
            void'(due_q.pop_back());
            void'(eu_q.pop_back());
            void'(ev_q.pop_back());
            void'(tid_q.pop_back());
        end
    endtask

    task automatic check_zero_outputs(input int tid);
        @(negedge clk);
        checks = checks + 1;
        test_checks[tid] = test_checks[tid] + 1;
        if (u_o != '0 || v_o != '0) begin
            $display("CHECK FAILED at %0t: test %0d outputs not cleared, u %h v %h",
                     $time, tid, u_o, v_o);
            errors = errors + 1;
            test_errs[tid] = test_errs[tid] + 1;
        end
    endtask

    task automatic report_test(input int tid);
        $display("Test %0d: %0d checks, %0d errors, %s", tid, test_checks[tid],
                 test_errs[tid], (test_errs[tid] == 0) ? "ok" : "FAILED");
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tb/butterfly_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tb/butterfly_trace.txt");
            return;
        end
        while (!$feof(fd) && trace_n < max_items) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%d %d %d %d %d %d %d", tr_id[trace_n],
                            tr_mode[trace_n], tr_u[trace_n], tr_v[trace_n],
                            tr_w[trace_n], tr_eu[trace_n], tr_ev[trace_n]);
                if (n == 7) begin
                    trace_n = trace_n + 1;
                end
            end
        end
        $fclose(fd);
    endtask

    // Compare each result at the cycle it becomes visible
    always @(negedge clk) begin
        int unsigned tid;
        int unsigned got_u;
        int unsigned got_v;
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            tid   = tid_q.pop_front();
            got_u = recombine(u_o);
            got_v = recombine(v_o);
            checks = checks + 1;
            test_checks[tid] = test_checks[tid] + 1;
            if (got_u != eu_q[0] || got_v != ev_q[0]) begin
                $display("CHECK FAILED at %0t: test %0d got u %0d v %0d, expected u %0d v %0d",
                         $time, tid, got_u, got_v, eu_q[0], ev_q[0]);
                errors = errors + 1;
                test_errs[tid] = test_errs[tid] + 1;
            end
            if (tid == 4) begin
                refresh_s0.push_back(u_o[0]);
            end
            void'(due_q.pop_front());
            void'(eu_q.pop_front());
            void'(ev_q.pop_front());
        end
    end

    // Watchdog sized from the trace length
    initial begin
        longint limit;
        wait (trace_n > 0);
        limit = longint'(trace_n + 20) * 8 * 10;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int k;
        int first;
        int tests_failed;
        bit all_same;
        void'($urandom(32'hdda7a9e9));
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        mode_i    = bf_gs;
        opu_i     = '0;
        opv_i     = '0;
        opw_i     = '0;
        rnd_i     = '0;
        for (int i = 0; i < 8; i++) begin
            test_checks[i] = 0;
            test_errs[i] = 0;
        end
        load_trace();
        if (trace_n == 0) begin
            $display("No trace items were read");
            errors = errors + 1;
        end
        step_cycle();
        step_cycle();
        reset_n <= 1'b1;
        check_zero_outputs(1);
        report_test(1);
        k = 0;
        while (k < trace_n) begin
            first = k;
            // Drain before any mode change
            repeat (8) drive_idle();
            cur_mode = (tr_mode[first] == 1) ? bf_pwm : bf_gs;
            if (tr_id[first] == 4) begin
                repeat (16) drive_item(first);
                k = k + 1;
            end else begin
                while (k < trace_n && tr_id[k] == tr_id[first]) begin
                    if (tr_id[k] == 5 && k - first == 3) begin
                        apply_zeroize();
                        drive_item(k);
                        check_zero_outputs(5);
                    end else begin
                        drive_item(k);
                    end
                    k = k + 1;
                end
            end
            repeat (8) drive_idle();
            if (tr_id[first] == 4) begin
                all_same = 1'b1;
                foreach (refresh_s0[i]) begin
                    if (refresh_s0[i] != refresh_s0[0]) begin
                        all_same = 1'b0;
                    end
                end
                if (refresh_s0.size() != 16 || all_same) begin
                    $display("CHECK FAILED at %0t: share 0 not refreshed over %0d results",
                             $time, refresh_s0.size());
                    errors = errors + 1;
                    test_errs[4] = test_errs[4] + 1;
                end
            end
            report_test(int'(tr_id[first]));
        end
        if (due_q.size() != 0) begin
            $display("Some expected results were never checked");
            errors = errors + 1;
        end
        tests_failed = 0;
        for (int i = 1; i < 6; i++) begin
            if (test_errs[i] != 0) begin
                tests_failed = tests_failed + 1;
            end
        end
        $display("Tests failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/butterfly_trace.txt */
# test mode(0 gs, 1 pwm) u v w expected_u expected_v
# all values decimal and unmasked, modulus 8380417
2 0 0 0 0 0 0
2 0 1 2 3 3 8380414
2 0 8380416 1 1 0 8380415
2 0 8380416 8380416 5 8380415 0
2 0 100 40 2 140 120
2 0 5 10 7 15 8380382
2 0 1000 1 1000 1001 999000
2 0 4096 0 4096 4096 16382
2 0 0 8380416 2 8380416 2
2 0 12345 345 100 12690 1200000
2 0 3000000 7000000 1 1619583 4380417
2 0 8380416 0 8380416 8380416 1
2 0 2 3 8380416 5 1
2 0 65536 1 65536 65537 4128256
3 1 0 5 0 0 0
3 1 7 6 0 42 0
3 1 8380416 8380416 0 1 0
3 1 8380416 2 0 8380415 0
3 1 4096 4096 0 16382 0
3 1 1000 1000 0 1000000 0
3 1 123 456 0 56088 0
3 1 1 8380416 0 8380416 0
4 0 1 2 3 3 8380414
5 0 10 20 30 30 8380117
5 0 50 25 4 75 100
5 0 9 9 9 18 0
5 0 1 0 8380416 1 8380416
5 0 20 10 3 30 30
5 0 0 1 1 1 8380416

/* sources.f */
+incdir+source
source/mask_pkg.sv
source/bf_mode_pkg.sv
source/masked_mod_add_sub.sv
source/masked_mod_mult.sv
source/masked_gs_butterfly.sv
tb/tb_masked_gs_butterfly.sv

/* Makefile */
# Verilator simulation of the masked butterfly

TOP       ?= tb_masked_gs_butterfly
FILELIST  ?= sources.f
LOG       ?= sim.log
VERILATOR ?= verilator

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
